//--- filelist.f
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_repl.sv
verilog/icache_top.sv
sim/icache_asserts.sv
sim/tb_icache.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_icache.sv
/* Instruction cache testbench */
`default_nettype none

module tb_icache;

  localparam int          CLK_PERIOD = 100;
  localparam int          DRIVE_DLY  = 10;
  localparam int          NSTEPS     = 25;
  localparam logic [31:0] WORD_KEY   = 32'hC0DE_5A5A;

  typedef enum logic [1:0] {
    OP_FETCH,
    OP_INV,
    OP_FLUSH
  } op_e;

  // one table row where the way only matters on a miss
  typedef struct packed {
    op_e                          op;
    icache_pkg::addr_t            addr;
    logic                         exp_hit;
    logic [icache_pkg::WAY_W-1:0] exp_way;
  } step_t;

  logic                           clk;
  logic                           rst_n;
  logic                           flush;
  logic                           req;
  icache_pkg::fetch_req_t         fetch_req;
  logic                           ready;
  logic                           valid;
  logic [icache_pkg::FETCH_W-1:0] fetch_data;
  logic                           busy;
  logic                           miss;
  logic                           mem_req;
  icache_pkg::mem_req_t           mem_data;
  logic                           mem_ack;
  logic                           mem_rtrn_vld;
  icache_pkg::mem_rtrn_t          mem_rtrn;
  step_t                          steps [NSTEPS];
  int                             seed;
  int                             err_cnt;

  icache_top UUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .flush_i        ( flush        ),
    .req_i          ( req          ),
    .fetch_req_i    ( fetch_req    ),
    .ready_o        ( ready        ),
    .valid_o        ( valid        ),
    .fetch_data_o   ( fetch_data   ),
    .busy_o         ( busy         ),
    .miss_o         ( miss         ),
    .mem_req_o      ( mem_req      ),
    .mem_data_o     ( mem_data     ),
    .mem_ack_i      ( mem_ack      ),
    .mem_rtrn_vld_i ( mem_rtrn_vld ),
    .mem_rtrn_i     ( mem_rtrn     )
  );

  initial begin : p_clk
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  //////////////////////////////////////////////////
  // memory model
  // each word is a fixed mix of its word address
  function automatic logic [31:0] model_word(input icache_pkg::addr_t addr);
    logic [13:0] waddr;
    waddr = addr[15:2];
    return {2'b00, waddr, 2'b00, waddr} ^ WORD_KEY;
  endfunction

  function automatic icache_pkg::line_t model_line(input icache_pkg::addr_t addr);
    icache_pkg::line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = model_word({addr[15:4], w[1:0], 2'b00});
    end
    return line;
  endfunction

  function automatic step_t make_step(input op_e op, input icache_pkg::addr_t addr,
                                      input logic exp_hit, input logic [1:0] exp_way);
    step_t s;
    s.op      = op;
    s.addr    = addr;
    s.exp_hit = exp_hit;
    s.exp_way = exp_way;
    return s;
  endfunction

  //////////////////////////////////////////////////
  // error exits
  task automatic stop_failed();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped after an error");
  endtask

  task automatic report_value(input string msg);
    err_cnt++;
    $display("FAIL at %0t: %s", $time, msg);
    stop_failed();
  endtask

  // drive point of the next cycle
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // walk over all sets with busy high until ready comes back
  task automatic check_flush_walk();
    for (int i = 0; i < icache_pkg::NUM_SETS; i++) begin
      @(negedge clk);
      assert (busy && !ready)
        else report_value($sformatf("flush cycle %0d busy=%b ready=%b", i, busy, ready));
      next_cycle();
    end
    @(negedge clk);
    assert (ready && !busy) else report_value("ready low after the flush walk");
    next_cycle();
  endtask

  task automatic run_fetch(input step_t s);
    int          lat = 0;
    int          n_req = 0;
    int          n_miss = 0;
    int          ack_in = 0;
    int          fill_in = 0;
    bit          pending = 1'b0;
    bit          got = 1'b0;
    bit          with_fill = 1'b0;
    logic [31:0] word;
    req            = 1'b1;
    fetch_req.addr = s.addr;
    @(negedge clk);
    while (!ready) begin
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    req = 1'b0;
    while (!got) begin
      @(negedge clk);
      lat++;
      if (miss) begin
        n_miss++;
      end
      if (!mem_req) begin
        pending = 1'b0;
      end else if (!pending) begin
        // new refill request answered after a random delay
        pending = 1'b1;
        n_req++;
        assert (lat == 1 && mem_data.paddr == {s.addr[15:4], 4'h0})
          else report_value($sformatf("refill paddr %h at cycle %0d for %h",
                                      mem_data.paddr, lat, s.addr));
        assert (mem_data.way == s.exp_way)
          else report_value($sformatf("victim way %0d, expected %0d",
                                      mem_data.way, s.exp_way));
        ack_in = 1 + int'($unsigned($random(seed)) % 4);
      end
      if (valid) begin
        got       = 1'b1;
        word      = fetch_data;
        with_fill = mem_rtrn_vld;
      end else begin
        next_cycle();
        mem_ack      = 1'b0;
        mem_rtrn_vld = 1'b0;
        if (fill_in > 0) begin
          fill_in--;
          if (fill_in == 0) begin
            mem_rtrn.rtype = icache_pkg::RTRN_IFILL;
            mem_rtrn.data  = model_line(s.addr);
            mem_rtrn_vld   = 1'b1;
          end
        end
        if (ack_in > 0) begin
          ack_in--;
          if (ack_in == 0) begin
            mem_ack = 1'b1;
            fill_in = 1 + int'($unsigned($random(seed)) % 4);
          end
        end
      end
    end
    next_cycle();
    mem_ack      = 1'b0;
    mem_rtrn_vld = 1'b0;
    if (s.exp_hit) begin
      assert (lat == 1 && n_req == 0 && n_miss == 0)
        else report_value($sformatf("hit on %h: latency %0d, %0d refills, %0d miss pulses",
                                    s.addr, lat, n_req, n_miss));
    end else begin
      assert (n_req == 1 && n_miss == 1 && with_fill)
        else report_value($sformatf("miss on %h: %0d refills, %0d miss pulses, fill %b",
                                    s.addr, n_req, n_miss, with_fill));
    end
    assert (word == model_word(s.addr))
      else report_value($sformatf("word at %h is %h, expected %h",
                                  s.addr, word, model_word(s.addr)));
  endtask

  task automatic run_inv(input step_t s);
    assert (!busy) else report_value("invalidation sent while the cache is busy");
    mem_rtrn.rtype   = icache_pkg::RTRN_INV;
    mem_rtrn.inv_idx = s.addr[7:4];
    mem_rtrn_vld     = 1'b1;
    @(negedge clk);
    assert (!ready) else report_value("ready high during an invalidation return");
    next_cycle();
    mem_rtrn_vld = 1'b0;
  endtask

  task automatic run_flush();
    flush = 1'b1;
    @(negedge clk);
    assert (!ready) else report_value("ready high with a flush pending");
    next_cycle();
    flush = 1'b0;
    check_flush_walk();
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  task automatic load_table();
    // set 3 takes four tags, set 5 a single line
    steps[0]  = make_step(OP_FETCH, 16'h1234, 1'b0, 2'd0);
    steps[1]  = make_step(OP_FETCH, 16'h1238, 1'b1, 2'd0);
    steps[2]  = make_step(OP_FETCH, 16'h123C, 1'b1, 2'd0);
    steps[3]  = make_step(OP_FETCH, 16'h3430, 1'b0, 2'd1);
    steps[4]  = make_step(OP_FETCH, 16'h5634, 1'b0, 2'd2);
    steps[5]  = make_step(OP_FETCH, 16'h7838, 1'b0, 2'd3);
    steps[6]  = make_step(OP_FETCH, 16'h1230, 1'b1, 2'd0);
    steps[7]  = make_step(OP_FETCH, 16'h343C, 1'b1, 2'd0);
    steps[8]  = make_step(OP_FETCH, 16'h5638, 1'b1, 2'd0);
    steps[9]  = make_step(OP_FETCH, 16'h7834, 1'b1, 2'd0);
    steps[10] = make_step(OP_FETCH, 16'hAB58, 1'b0, 2'd0);
    // drop set 3, set 5 stays
    steps[11] = make_step(OP_INV,   16'h0030, 1'b0, 2'd0);
    steps[12] = make_step(OP_FETCH, 16'h5630, 1'b0, 2'd0);
    steps[13] = make_step(OP_FETCH, 16'hAB54, 1'b1, 2'd0);
    steps[14] = make_step(OP_FETCH, 16'h1234, 1'b0, 2'd1);
    steps[15] = make_step(OP_FETCH, 16'h3438, 1'b0, 2'd2);
    steps[16] = make_step(OP_FETCH, 16'h7830, 1'b0, 2'd3);
    steps[17] = make_step(OP_FETCH, 16'h1238, 1'b1, 2'd0);
    // every line held before the flush has to refill
    steps[18] = make_step(OP_FLUSH, 16'h0000, 1'b0, 2'd0);
    steps[19] = make_step(OP_FETCH, 16'h1234, 1'b0, 2'd0);
    steps[20] = make_step(OP_FETCH, 16'hAB5C, 1'b0, 2'd0);
    steps[21] = make_step(OP_FETCH, 16'h5630, 1'b0, 2'd1);
    steps[22] = make_step(OP_FETCH, 16'h343C, 1'b0, 2'd2);
    steps[23] = make_step(OP_FETCH, 16'h7834, 1'b0, 2'd3);
    steps[24] = make_step(OP_FETCH, 16'hAB50, 1'b1, 2'd0);
  endtask

  initial begin : p_main
    seed         = 35463;
    err_cnt      = 0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    req          = 1'b0;
    fetch_req    = '0;
    mem_ack      = 1'b0;
    mem_rtrn_vld = 1'b0;
    mem_rtrn     = '0;
    load_table();
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    // reset walk clears every set
    check_flush_walk();
    foreach (steps[i]) begin
      case (steps[i].op)
        OP_FETCH: run_fetch(steps[i]);
        OP_INV:   run_inv(steps[i]);
        default:  run_flush();
      endcase
    end
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_failed();
    end
  end

  // generous bound per table row
  initial begin : p_watchdog
    #(NSTEPS * 20 * CLK_PERIOD);
    $display("watchdog expired before the test table finished");
    stop_failed();
  end

endmodule

`default_nettype wire

//--- sim/icache_asserts.sv
/* Cache protocol assertions */
`default_nettype none

module icache_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 mem_req_i,
  input logic                 mem_ack_i,
  input icache_pkg::mem_req_t mem_data_i,
  input logic                 valid_i,
  input logic                 flush_en_i,
  input icache_pkg::way_oh_t  hit_oh_i
);

  // refill request holds with stable address and way until acked
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_data_i))
    else $error("refill request dropped or changed before ack");

  // no response while the sets are being cleared
  a_no_valid_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(valid_i && flush_en_i))
    else $error("fetch response during flush");

  // a line lives in one way only
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_oh_i))
    else $error("more than one way hit");

endmodule

bind icache_top icache_asserts u_asserts (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .mem_req_i  ( mem_req_o  ),
  .mem_ack_i  ( mem_ack_i  ),
  .mem_data_i ( mem_data_o ),
  .valid_i    ( valid_o    ),
  .flush_en_i ( flush_en   ),
  .hit_oh_i   ( hit_oh     )
);

`default_nettype wire

//--- verilog/icache_top.sv
/* Set-associative instruction cache */
`default_nettype none

module icache_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           req_i,
  input  icache_pkg::fetch_req_t         fetch_req_i,
  output logic                           ready_o,
  output logic                           valid_o,
  output logic [icache_pkg::FETCH_W-1:0] fetch_data_o,
  output logic                           busy_o,
  output logic                           miss_o,
  output logic                           mem_req_o,
  output icache_pkg::mem_req_t           mem_data_o,
  input  logic                           mem_ack_i,
  input  logic                           mem_rtrn_vld_i,
  input  icache_pkg::mem_rtrn_t          mem_rtrn_i
);

  icache_pkg::addr_t              addr_d, addr_q;
  logic                           accept;
  logic [icache_pkg::INDEX_W-1:0] index;
  logic [icache_pkg::TAG_W-1:0]   tag_q;
  logic [icache_pkg::INDEX_W-1:0] index_q;
  logic                           hit;
  logic                           cache_rden, cache_wren, cmp_en;
  logic                           inv_en, flush_en;
  logic [icache_pkg::INDEX_W-1:0] flush_idx;
  icache_pkg::way_oh_t            hit_oh, valid_ways, victim_oh;
  logic [icache_pkg::WAY_W-1:0]   victim;

  //////////////////////////////////////////////////
  // request address
  assign accept = req_i & ready_o;
  // arrays see the new index in the accept cycle
  assign addr_d = accept ? fetch_req_i.addr : addr_q;

  always_ff @(posedge clk_i) begin : p_addr
    addr_q <= addr_d;
  end

  assign index   = addr_d[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign index_q = addr_q[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign tag_q   = addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign hit     = |hit_oh;

  // refill is always a whole line
  assign mem_data_o.paddr = {tag_q, index_q, {icache_pkg::OFFSET_W{1'b0}}};
  assign mem_data_o.way   = victim;

  //////////////////////////////////////////////////
  // blocks
  icache_ctrl i_ctrl (
    .clk_i          ( clk_i            ),
    .rst_ni         ( rst_ni           ),
    .flush_i        ( flush_i          ),
    .req_i          ( req_i            ),
    .hit_i          ( hit              ),
    .mem_ack_i      ( mem_ack_i        ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i   ),
    .rtrn_type_i    ( mem_rtrn_i.rtype ),
    .ready_o        ( ready_o          ),
    .valid_o        ( valid_o          ),
    .busy_o         ( busy_o           ),
    .miss_o         ( miss_o           ),
    .mem_req_o      ( mem_req_o        ),
    .cache_rden_o   ( cache_rden       ),
    .cache_wren_o   ( cache_wren       ),
    .cmp_en_o       ( cmp_en           ),
    .inv_en_o       ( inv_en           ),
    .flush_en_o     ( flush_en         ),
    .flush_idx_o    ( flush_idx        )
  );

  icache_tag_array i_tag_array (
    .clk_i       ( clk_i              ),
    .rst_ni      ( rst_ni             ),
    .rden_i      ( cache_rden         ),
    .wren_i      ( cache_wren         ),
    .inv_en_i    ( inv_en             ),
    .flush_en_i  ( flush_en           ),
    .flush_idx_i ( flush_idx          ),
    .inv_idx_i   ( mem_rtrn_i.inv_idx ),
    .index_i     ( index              ),
    .tag_i       ( tag_q              ),
    .victim_oh_i ( victim_oh          ),
    .hit_oh_o    ( hit_oh             ),
    .valid_o     ( valid_ways         )
  );

  icache_data_array i_data_array (
    .clk_i       ( clk_i                                ),
    .rden_i      ( cache_rden                           ),
    .wren_i      ( cache_wren                           ),
    .index_i     ( index                                ),
    .offset_i    ( addr_q[icache_pkg::OFFSET_W-1:0]     ),
    .victim_oh_i ( victim_oh                            ),
    .hit_oh_i    ( hit_oh                               ),
    .cmp_en_i    ( cmp_en                               ),
    .fill_line_i ( mem_rtrn_i.data                      ),
    .data_o      ( fetch_data_o                         )
  );

  icache_repl i_repl (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .valid_i     ( valid_ways ),
    .cmp_en_i    ( cmp_en     ),
    .fill_i      ( cache_wren ),
    .victim_o    ( victim     ),
    .victim_oh_o ( victim_oh  )
  );

endmodule

`default_nettype wire

//--- verilog/icache_repl.sv
/* Way replacement */
`default_nettype none

module icache_repl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  icache_pkg::way_oh_t          valid_i,
  input  logic                         cmp_en_i,
  input  logic                         fill_i,
  output logic [icache_pkg::WAY_W-1:0] victim_o,
  output icache_pkg::way_oh_t          victim_oh_o
);

  logic [icache_pkg::LFSR_W-1:0] lfsr_q;
  logic [icache_pkg::WAY_W-1:0]  inv_way;
  logic                          all_valid;

  assign all_valid = &valid_i;

  // lowest invalid way by position
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = w[icache_pkg::WAY_W-1:0];
      end
    end
  end

  // x^4 + x^3 + 1, steps only when a full set gets a line
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= icache_pkg::LFSR_SEED;
    end else if (fill_i && all_valid) begin
      lfsr_q <= {lfsr_q[icache_pkg::LFSR_W-2:0],
                 lfsr_q[icache_pkg::LFSR_W-1] ^ lfsr_q[icache_pkg::LFSR_W-2]};
    end
  end

  assign victim_o = all_valid ? lfsr_q[icache_pkg::WAY_W-1:0] : inv_way;

  // capture the victim of the lookup for the later fill
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_victim
    if (!rst_ni) begin
      victim_oh_o <= '0;
    end else if (cmp_en_i) begin
      victim_oh_o <= icache_pkg::way_oh_t'(1) << victim_o;
    end
  end

endmodule

`default_nettype wire

//--- verilog/icache_data_array.sv
/* Line data arrays */
`default_nettype none

module icache_data_array (
  input  logic                           clk_i,
  input  logic                           rden_i,
  input  logic                           wren_i,
  input  logic [icache_pkg::INDEX_W-1:0] index_i,
  input  logic [icache_pkg::OFFSET_W-1:0] offset_i,
  input  icache_pkg::way_oh_t            victim_oh_i,
  input  icache_pkg::way_oh_t            hit_oh_i,
  input  logic                           cmp_en_i,
  input  icache_pkg::line_t              fill_line_i,
  output logic [icache_pkg::FETCH_W-1:0] data_o
);

  icache_pkg::line_t                 line_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
  icache_pkg::line_t                 line_rdata [icache_pkg::NUM_WAYS];
  logic [icache_pkg::FETCH_W-1:0]    hit_word;
  logic [icache_pkg::WORD_IDX_W-1:0] word_idx;

  // drop the byte lanes, keep the word number
  assign word_idx = offset_i[icache_pkg::OFFSET_W-1 -: icache_pkg::WORD_IDX_W];

  always_ff @(posedge clk_i) begin : p_mem
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      // fill writes the whole line into the victim way
      if (wren_i && victim_oh_i[w]) begin
        line_mem[w][index_i] <= fill_line_i;
      end
      if (rden_i) begin
        line_rdata[w] <= line_mem[w][index_i];
      end
    end
  end

  // hit is one-hot, lowest way wins otherwise
  always_comb begin : p_sel
    hit_word = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_oh_i[w]) begin
        hit_word = line_rdata[w][word_idx*icache_pkg::FETCH_W +: icache_pkg::FETCH_W];
      end
    end
  end

  // during a fill the word bypasses the array
  assign data_o = cmp_en_i ? hit_word :
                  fill_line_i[word_idx*icache_pkg::FETCH_W +: icache_pkg::FETCH_W];

endmodule

`default_nettype wire

//--- verilog/icache_tag_array.sv
/* Tag and valid arrays */
`default_nettype none

module icache_tag_array (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rden_i,
  input  logic                           wren_i,
  input  logic                           inv_en_i,
  input  logic                           flush_en_i,
  input  logic [icache_pkg::INDEX_W-1:0] flush_idx_i,
  input  logic [icache_pkg::INDEX_W-1:0] inv_idx_i,
  input  logic [icache_pkg::INDEX_W-1:0] index_i,
  input  logic [icache_pkg::TAG_W-1:0]   tag_i,
  input  icache_pkg::way_oh_t            victim_oh_i,
  output icache_pkg::way_oh_t            hit_oh_o,
  output icache_pkg::way_oh_t            valid_o
);

  logic [icache_pkg::TAG_W-1:0]   tag_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
  icache_pkg::way_oh_t            vld_mem [icache_pkg::NUM_SETS];
  logic [icache_pkg::TAG_W-1:0]   tag_rdata [icache_pkg::NUM_WAYS];
  icache_pkg::way_oh_t            vld_rdata;
  logic [icache_pkg::INDEX_W-1:0] addr;
  icache_pkg::way_oh_t            way_en;
  logic                           vld_we;

  // flush beats invalidation, lookup index last
  assign addr = flush_en_i ? flush_idx_i :
                inv_en_i   ? inv_idx_i   :
                             index_i;

  // clears hit every way of the set, a fill only the victim
  assign way_en = (flush_en_i || inv_en_i) ? '1 : victim_oh_i;
  assign vld_we = wren_i | inv_en_i | flush_en_i;

  // valid bits, set on fill and cleared otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld_mem
    if (!rst_ni) begin
      vld_mem <= '{default: '0};
    end else begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (vld_we && way_en[w]) begin
          vld_mem[addr][w] <= wren_i;
        end
      end
    end
  end

  // tags only change on fill
  always_ff @(posedge clk_i) begin : p_tag_mem
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (wren_i && victim_oh_i[w]) begin
        tag_mem[w][addr] <= tag_i;
      end
      if (rden_i) begin
        tag_rdata[w] <= tag_mem[w][addr];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld_rd
    if (!rst_ni) begin
      vld_rdata <= '0;
    end else if (rden_i) begin
      vld_rdata <= vld_mem[addr];
    end
  end

  // compare against the tag of the request in lookup
  always_comb begin : p_hit
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_oh_o[w] = vld_rdata[w] && (tag_rdata[w] == tag_i);
    end
  end

  assign valid_o = vld_rdata;

endmodule

`default_nettype wire

//--- verilog/icache_ctrl.sv
/* Instruction cache controller */
`default_nettype none

module icache_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           req_i,
  input  logic                           hit_i,
  input  logic                           mem_ack_i,
  input  logic                           mem_rtrn_vld_i,
  input  icache_pkg::rtrn_type_e         rtrn_type_i,
  output logic                           ready_o,
  output logic                           valid_o,
  output logic                           busy_o,
  output logic                           miss_o,
  output logic                           mem_req_o,
  output logic                           cache_rden_o,
  output logic                           cache_wren_o,
  output logic                           cmp_en_o,
  output logic                           inv_en_o,
  output logic                           flush_en_o,
  output logic [icache_pkg::INDEX_W-1:0] flush_idx_o
);

  icache_pkg::ctrl_state_e              state_d, state_q;
  logic                                 flush_d, flush_q;
  logic                                 cmp_en_d, cmp_en_q;
  logic [icache_pkg::INDEX_W-1:0]       flush_cnt_d, flush_cnt_q;
  logic                                 flush_done;
  logic                                 fill_rtrn;

  // returns are consumed unconditionally
  assign fill_rtrn = mem_rtrn_vld_i && (rtrn_type_i == icache_pkg::RTRN_IFILL);
  assign inv_en_o  = mem_rtrn_vld_i && (rtrn_type_i == icache_pkg::RTRN_INV);

  assign busy_o   = (state_q != icache_pkg::IDLE);
  assign cmp_en_o = cmp_en_q;

  //////////////////////////////////////////////////
  // flush walk over one set per cycle
  assign flush_en_o  = (state_q == icache_pkg::FLUSH);
  assign flush_done  = flush_en_o && (flush_cnt_q == icache_pkg::LAST_SET);
  assign flush_idx_o = flush_cnt_q;
  assign flush_cnt_d = flush_done ? '0 :
                       flush_en_o ? flush_cnt_q + icache_pkg::INDEX_W'(1) :
                                    flush_cnt_q;

  //////////////////////////////////////////////////
  // main fsm
  always_comb begin : p_fsm
    state_d      = state_q;
    // hold a flush request until the walk starts
    flush_d      = flush_q | flush_i;
    cmp_en_d     = 1'b0;
    ready_o      = 1'b0;
    valid_o      = 1'b0;
    miss_o       = 1'b0;
    mem_req_o    = 1'b0;
    cache_rden_o = 1'b0;
    cache_wren_o = 1'b0;

    unique case (state_q)
      icache_pkg::FLUSH: begin
        if (flush_done) begin
          state_d = icache_pkg::IDLE;
          flush_d = 1'b0;
        end
      end
      icache_pkg::IDLE: begin
        cmp_en_d = 1'b1;
        if (flush_d) begin
          state_d = icache_pkg::FLUSH;
        // a return this cycle owns the array port
        end else if (!mem_rtrn_vld_i) begin
          ready_o = 1'b1;
          if (req_i) begin
            cache_rden_o = 1'b1;
            state_d      = icache_pkg::READ;
          end
        end
      end
      icache_pkg::READ: begin
        cmp_en_d = 1'b1;
        if (hit_i) begin
          valid_o = 1'b1;
          state_d = icache_pkg::IDLE;
          // back-to-back lookup unless a flush is waiting
          if (!flush_d && !mem_rtrn_vld_i) begin
            ready_o = 1'b1;
            if (req_i) begin
              cache_rden_o = 1'b1;
              state_d      = icache_pkg::READ;
            end
          end
        end else begin
          // on a miss the refill request holds until acked
          cmp_en_d  = 1'b0;
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = icache_pkg::MISS;
          end
        end
      end
      icache_pkg::MISS: begin
        // word comes straight from the return line
        if (fill_rtrn) begin
          valid_o      = 1'b1;
          cache_wren_o = 1'b1;
          state_d      = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= icache_pkg::FLUSH;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      cmp_en_q    <= cmp_en_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/icache_pkg.sv
/* Instruction cache shared types */
`default_nettype none

package icache_pkg;

  // cache geometry
  localparam int unsigned ADDR_W   = 16;
  localparam int unsigned FETCH_W  = 32;
  localparam int unsigned LINE_W   = 128;
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned WAY_W    = 2;
  localparam int unsigned NUM_SETS = 16;
  localparam int unsigned INDEX_W  = 4;
  localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // word select inside a line, the two low offset bits are byte lanes
  localparam int unsigned WORD_IDX_W = OFFSET_W - 2;
  // last set visited by the flush walk
  localparam logic [INDEX_W-1:0] LAST_SET = INDEX_W'(NUM_SETS - 1);

  // replacement lfsr, seed must be nonzero
  localparam int unsigned       LFSR_W    = 4;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 4'b1001;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [NUM_WAYS-1:0] way_oh_t;

  // kind of packet on the return port
  typedef enum logic {
    RTRN_IFILL,
    RTRN_INV
  } rtrn_type_e;

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // line-aligned refill address plus the way that will take the line
  typedef struct packed {
    addr_t            paddr;
    logic [WAY_W-1:0] way;
  } mem_req_t;

  typedef struct packed {
    rtrn_type_e         rtype;
    line_t              data;
    logic [INDEX_W-1:0] inv_idx;
  } mem_rtrn_t;

endpackage

`default_nettype wire
